/* pipelined_core.f */
common/core_pkg.sv
source/fetch_unit.sv
decode/register_file.sv
decode/decode_unit.sv
source/execute_unit.sv
source/result_unit.sv
source/pipelined_core.sv
testbench/core_tb.sv

/* Makefile */
TOP := core_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f pipelined_core.f -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

lint:
	verilator --lint-only -Wall --top-module pipelined_core \
		common/core_pkg.sv source/fetch_unit.sv decode/register_file.sv \
		decode/decode_unit.sv source/execute_unit.sv source/result_unit.sv \
		source/pipelined_core.sv

clean:
	rm -rf obj_dir $(LOG)

/* testbench/core_tb.sv */
`default_nettype none

module core_tb import core_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 8;
    localparam int reset_cycles = 10;
    localparam int program_words = 64;
    localparam int cycles_per_instr = 4;
    localparam int timeout_ns =
        2 * (reset_cycles + program_words * cycles_per_instr) * clk_period;

    logic clk;
    logic rst;
    word_t imem_data;
    word_t imem_addr;
    logic retire_valid;
    word_t retire_pc;
    reg_addr_t retire_rd;
    word_t retire_data;

    int seed;
    word_t program_mem [program_words];
    word_t model_regs [32];
    word_t model_pc;

    pipelined_core pipelined_core_inst (
        .clk          ( clk ),
        .rst          ( rst ),
        .imem_data    ( imem_data ),
        .imem_addr    ( imem_addr ),
        .retire_valid ( retire_valid ),
        .retire_pc    ( retire_pc ),
        .retire_rd    ( retire_rd ),
        .retire_data  ( retire_data )
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // instruction port answers in the same cycle, nops past the program
    always_comb begin
        if (imem_addr < program_words * 4) begin
            imem_data = program_mem[imem_addr[7:2]];
        end else begin
            imem_data = nop_instruction;
        end
    end

    task automatic stop_with_mismatch(input string name, input word_t expected,
                                      input word_t actual);
        $display("mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        $display("Done: errors found");
        $fatal(1);
    endtask

    // random mix of the supported instructions over x0..x7, so dependencies are frequent
    task automatic make_program();
        int r;
        int r2;
        int offset_words;
        logic [3:0] kind;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm12;
        logic [12:0] boff;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        for (int i = 0; i < program_words; i++) begin
            r = $random(seed);
            r2 = $random(seed);
            rd = {2'b00, r[6:4]};
            rs1 = {2'b00, r[9:7]};
            rs2 = {2'b00, r[12:10]};
            f3 = r[15:13];
            if (f3 == 3'b011) begin
                f3 = funct3_add_sub; // sltu is not supported
            end
            imm12 = r[27:16];
            kind = r[31:28];
            if (kind < 4'd6) begin
                if (f3 == funct3_sll || f3 == funct3_srl) begin
                    imm12 = {7'b0, imm12[4:0]};
                end
                program_mem[i] = {imm12, rs1, f3, rd, opcode_op_imm};
            end else if (kind < 4'd11) begin
                f7 = (f3 == funct3_add_sub && imm12[0]) ? funct7_alt : 7'b0;
                program_mem[i] = {f7, rs2, rs1, f3, rd, opcode_op};
            end else if (kind < 4'd13) begin
                program_mem[i] = {r2[19:0], rd, opcode_lui};
            end else begin
                // forward only, two to eight instructions
                offset_words = 2 + int'($unsigned(r2) % 7);
                boff = 13'(offset_words * 4);
                f3 = imm12[0] ? funct3_bne : funct3_beq;
                program_mem[i] = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1],
                                  boff[11], opcode_branch};
            end
        end
    endtask

    function automatic word_t arith(input logic [2:0] f3, input logic sub,
                                    input word_t a, input word_t b);
        case (f3)
            funct3_add_sub: return sub ? a - b : a + b;
            funct3_sll:     return a << b[4:0];
            funct3_slt:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            funct3_xor:     return a ^ b;
            funct3_srl:     return a >> b[4:0];
            funct3_or:      return a | b;
            funct3_and:     return a & b;
            default:        return '0;
        endcase
    endfunction

    // executes the instruction at model_pc against the model's registers
    task automatic model_step(output word_t exp_data, output reg_addr_t exp_rd);
        word_t instr;
        word_t a;
        word_t b;
        word_t imm_i;
        word_t imm_b;
        word_t next_pc;
        instr = program_mem[model_pc[7:2]];
        a = model_regs[instr[19:15]];
        b = model_regs[instr[24:20]];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        next_pc = model_pc + pc_step;
        exp_rd = instr[11:7];
        exp_data = '0;
        case (instr[6:0])
            opcode_op_imm: exp_data = arith(instr[14:12], 1'b0, a, imm_i);
            opcode_op:     exp_data = arith(instr[14:12], instr[31:25] == funct7_alt, a, b);
            opcode_lui:    exp_data = {instr[31:12], 12'b0};
            opcode_branch: begin
                exp_rd = '0; // branches retire the offset and write nothing
                exp_data = imm_b;
                if ((instr[14:12] == funct3_beq) ? (a == b) : (a != b)) begin
                    next_pc = model_pc + imm_b;
                end
            end
            default: exp_rd = '0;
        endcase
        if (exp_rd != '0) begin
            model_regs[exp_rd] = exp_data; // x0 stays zero
        end
        model_pc = next_pc;
    endtask

    initial begin
        word_t exp_pc;
        word_t exp_data;
        reg_addr_t exp_rd;
        seed = 65067;
        rst = 1'b0;
        make_program();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        model_pc = reset_pc;

        repeat (reset_cycles - 1) @(posedge clk);
        @(negedge clk);
        assert (imem_addr == reset_pc)
            else stop_with_mismatch("imem_addr", reset_pc, imem_addr);
        assert (retire_valid == 1'b0)
            else stop_with_mismatch("retire_valid", 32'd0, {31'd0, retire_valid});
        @(posedge clk);
        rst <= 1'b1;

        // compare every retirement in program order until the model leaves the array
        while (model_pc < program_words * 4) begin
            @(negedge clk);
            if (retire_valid) begin
                exp_pc = model_pc;
                model_step(exp_data, exp_rd);
                assert (retire_pc == exp_pc)
                    else stop_with_mismatch("retire_pc", exp_pc, retire_pc);
                assert (retire_rd == exp_rd)
                    else stop_with_mismatch("retire_rd", {27'd0, exp_rd}, {27'd0, retire_rd});
                assert (retire_data == exp_data)
                    else stop_with_mismatch("retire_data", exp_data, retire_data);
            end
        end
        $display("Done: no errors");
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("timeout: the core did not retire the whole program in time");
        $display("Done: errors found");
        $fatal(1);
    end

endmodule

`default_nettype wire

/* source/pipelined_core.sv */
`default_nettype none

module pipelined_core import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  word_t     imem_data,
    output word_t     imem_addr,
    output logic      retire_valid,
    output word_t     retire_pc,
    output reg_addr_t retire_rd,
    output word_t     retire_data
);
    // fetch to decode
    logic fetch_valid;
    word_t fetch_pc;
    word_t fetch_instruction;
    logic decode_stall;
    logic redirect_valid;
    word_t redirect_target;

    // register file ports
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t rs1_data;
    word_t rs2_data;
    logic write_enable;
    reg_addr_t write_rd;
    word_t write_data;

    // decode to execute
    logic exec_valid;
    word_t exec_pc;
    alu_op_t exec_alu_op;
    word_t exec_a;
    word_t exec_b;
    reg_addr_t exec_rd;

    // execute to result
    logic result_valid;
    word_t result_pc;
    reg_addr_t result_rd;
    word_t result_data;

    fetch_unit fetch_unit_inst (
        .clk               ( clk ),
        .rst               ( rst ),
        .decode_stall      ( decode_stall ),
        .redirect_valid    ( redirect_valid ),
        .redirect_target   ( redirect_target ),
        .imem_data         ( imem_data ),
        .imem_addr         ( imem_addr ),
        .fetch_valid       ( fetch_valid ),
        .fetch_pc          ( fetch_pc ),
        .fetch_instruction ( fetch_instruction )
    );

    decode_unit decode_unit_inst (
        .clk               ( clk ),
        .rst               ( rst ),
        .fetch_valid       ( fetch_valid ),
        .fetch_pc          ( fetch_pc ),
        .fetch_instruction ( fetch_instruction ),
        .rs1_data          ( rs1_data ),
        .rs2_data          ( rs2_data ),
        .result_rd         ( result_rd ),
        .rs1_addr          ( rs1_addr ),
        .rs2_addr          ( rs2_addr ),
        .decode_stall      ( decode_stall ),
        .redirect_valid    ( redirect_valid ),
        .redirect_target   ( redirect_target ),
        .exec_valid        ( exec_valid ),
        .exec_pc           ( exec_pc ),
        .exec_alu_op       ( exec_alu_op ),
        .exec_a            ( exec_a ),
        .exec_b            ( exec_b ),
        .exec_rd           ( exec_rd )
    );

    register_file register_file_inst (
        .clk          ( clk ),
        .rst          ( rst ),
        .rs1_addr     ( rs1_addr ),
        .rs2_addr     ( rs2_addr ),
        .write_enable ( write_enable ),
        .write_rd     ( write_rd ),
        .write_data   ( write_data ),
        .rs1_data     ( rs1_data ),
        .rs2_data     ( rs2_data )
    );

    execute_unit execute_unit_inst (
        .clk          ( clk ),
        .rst          ( rst ),
        .exec_valid   ( exec_valid ),
        .exec_pc      ( exec_pc ),
        .exec_alu_op  ( exec_alu_op ),
        .exec_a       ( exec_a ),
        .exec_b       ( exec_b ),
        .exec_rd      ( exec_rd ),
        .result_valid ( result_valid ),
        .result_pc    ( result_pc ),
        .result_rd    ( result_rd ),
        .result_data  ( result_data )
    );

    result_unit result_unit_inst (
        .result_valid ( result_valid ),
        .result_pc    ( result_pc ),
        .result_rd    ( result_rd ),
        .result_data  ( result_data ),
        .write_enable ( write_enable ),
        .write_rd     ( write_rd ),
        .write_data   ( write_data ),
        .retire_valid ( retire_valid ),
        .retire_pc    ( retire_pc ),
        .retire_rd    ( retire_rd ),
        .retire_data  ( retire_data )
    );

endmodule

`default_nettype wire

/* source/result_unit.sv */
`default_nettype none

module result_unit import core_pkg::*; (
    input  logic      result_valid,
    input  word_t     result_pc,
    input  reg_addr_t result_rd,
    input  word_t     result_data,
    output logic      write_enable,
    output reg_addr_t write_rd,
    output word_t     write_data,
    output logic      retire_valid,
    output word_t     retire_pc,
    output reg_addr_t retire_rd,
    output word_t     retire_data
);
    // writes to x0 are dropped here
    assign write_enable = result_valid && result_rd != '0;
    assign write_rd = result_rd;
    assign write_data = result_data;

    // retire lines up with the register write
    assign retire_valid = result_valid;
    assign retire_pc = result_pc;
    assign retire_rd = result_rd;
    assign retire_data = result_data;

endmodule

`default_nettype wire

/* source/execute_unit.sv */
`default_nettype none

module execute_unit import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      exec_valid,
    input  word_t     exec_pc,
    input  alu_op_t   exec_alu_op,
    input  word_t     exec_a,
    input  word_t     exec_b,
    input  reg_addr_t exec_rd,
    output logic      result_valid,
    output word_t     result_pc,
    output reg_addr_t result_rd,
    output word_t     result_data
);
    word_t alu_result;
    logic [4:0] shamt;

    assign shamt = exec_b[4:0];

    always_comb begin
        case (exec_alu_op)
            alu_add: alu_result = exec_a + exec_b;
            alu_sub: alu_result = exec_a - exec_b;
            alu_slt: alu_result = {{(xlen-1){1'b0}}, $signed(exec_a) < $signed(exec_b)};
            alu_xor: alu_result = exec_a ^ exec_b;
            alu_or:  alu_result = exec_a | exec_b;
            alu_and: alu_result = exec_a & exec_b;
            alu_sll: alu_result = exec_a << shamt;
            alu_srl: alu_result = exec_a >> shamt; // logical only
            default: alu_result = exec_b;
        endcase
    end

    // result_rd also feeds the contention check in decode
    always_ff @(posedge clk) begin
        if (!rst) begin
            result_valid <= 1'b0;
            result_rd <= '0;
        end else begin
            result_valid <= exec_valid;
            result_rd <= exec_rd; // zero for a bubble
        end
    end

    always_ff @(posedge clk) begin
        if (exec_valid) begin
            result_pc <= exec_pc;
            result_data <= alu_result;
        end
    end

endmodule

`default_nettype wire

/* decode/decode_unit.sv */
`default_nettype none

module decode_unit import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      fetch_valid,
    input  word_t     fetch_pc,
    input  word_t     fetch_instruction,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  reg_addr_t result_rd,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output logic      decode_stall,
    output logic      redirect_valid,
    output word_t     redirect_target,
    output logic      exec_valid,
    output word_t     exec_pc,
    output alu_op_t   exec_alu_op,
    output word_t     exec_a,
    output word_t     exec_b,
    output reg_addr_t exec_rd
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t rd;
    word_t imm_i;
    word_t imm_u;
    word_t imm_b;

    logic uses_rs1;
    logic uses_rs2;
    logic writes_rd;
    logic is_branch;
    alu_op_t alu_op;
    word_t operand_b;
    reg_addr_t dest;

    logic rs1_hit;
    logic rs2_hit;
    logic taken;
    logic transfer;

    function automatic alu_op_t funct3_to_alu(input logic [2:0] f3);
        case (f3)
            funct3_slt: return alu_slt;
            funct3_xor: return alu_xor;
            funct3_or:  return alu_or;
            funct3_and: return alu_and;
            funct3_sll: return alu_sll;
            funct3_srl: return alu_srl;
            default:    return alu_add;
        endcase
    endfunction

    assign opcode = fetch_instruction[6:0];
    assign rd = fetch_instruction[11:7];
    assign funct3 = fetch_instruction[14:12];
    assign rs1_addr = fetch_instruction[19:15];
    assign rs2_addr = fetch_instruction[24:20];
    assign funct7 = fetch_instruction[31:25];

    assign imm_i = {{20{fetch_instruction[31]}}, fetch_instruction[31:20]};
    assign imm_u = {fetch_instruction[31:12], 12'b0};
    assign imm_b = {{20{fetch_instruction[31]}}, fetch_instruction[7],
                    fetch_instruction[30:25], fetch_instruction[11:8], 1'b0};

    always_comb begin
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        writes_rd = 1'b0;
        is_branch = 1'b0;
        alu_op = alu_pass_b;
        operand_b = imm_i;
        case (opcode)
            opcode_op_imm: begin
                uses_rs1 = 1'b1;
                writes_rd = 1'b1;
                alu_op = funct3_to_alu(funct3);
            end
            opcode_op: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                writes_rd = 1'b1;
                operand_b = rs2_data;
                if (funct3 == funct3_add_sub && funct7 == funct7_alt) begin
                    alu_op = alu_sub;
                end else begin
                    alu_op = funct3_to_alu(funct3);
                end
            end
            opcode_lui: begin
                writes_rd = 1'b1;
                operand_b = imm_u;
            end
            opcode_branch: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                is_branch = 1'b1;
                operand_b = imm_b; // retired, never written
            end
            default: ;
        endcase
    end

    assign dest = writes_rd ? rd : '0;

    // exec_rd and result_rd are zero when nothing is written there
    assign rs1_hit = uses_rs1 && rs1_addr != '0
                     && (rs1_addr == exec_rd || rs1_addr == result_rd);
    assign rs2_hit = uses_rs2 && rs2_addr != '0
                     && (rs2_addr == exec_rd || rs2_addr == result_rd);

    assign decode_stall = fetch_valid && (rs1_hit || rs2_hit);
    assign transfer = fetch_valid && !decode_stall;

    always_comb begin
        case (funct3)
            funct3_beq: taken = rs1_data == rs2_data;
            funct3_bne: taken = rs1_data != rs2_data;
            default:    taken = 1'b0;
        endcase
    end

    assign redirect_valid = transfer && is_branch && taken;
    assign redirect_target = fetch_pc + imm_b;

    always_ff @(posedge clk) begin
        if (!rst) begin
            exec_valid <= 1'b0;
            exec_rd <= '0;
        end else begin
            exec_valid <= transfer;
            exec_rd <= transfer ? dest : '0; // bubble writes nothing
        end
    end

    always_ff @(posedge clk) begin
        if (transfer) begin
            exec_pc <= fetch_pc;
            exec_alu_op <= alu_op;
            exec_a <= rs1_data;
            exec_b <= operand_b;
        end
    end

endmodule

`default_nettype wire

/* decode/register_file.sv */
`default_nettype none

module register_file import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  logic      write_enable,
    input  reg_addr_t write_rd,
    input  word_t     write_data,
    output word_t     rs1_data,
    output word_t     rs2_data
);
    word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_rd != '0) begin
            regs[write_rd] <= write_data;
        end
    end

    // x0 is hardwired
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`default_nettype none

module fetch_unit import core_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  decode_stall,
    input  logic  redirect_valid,
    input  word_t redirect_target,
    input  word_t imem_data,
    output word_t imem_addr,
    output logic  fetch_valid,
    output word_t fetch_pc,
    output word_t fetch_instruction
);
    word_t pc;

    assign imem_addr = pc; // instruction comes back in the same cycle

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= reset_pc;
            fetch_valid <= 1'b0;
        end else if (redirect_valid) begin
            // taken branch in decode, the word fetched now is on the wrong path
            pc <= redirect_target;
            fetch_valid <= 1'b0;
        end else if (!decode_stall) begin
            pc <= pc + pc_step;
            fetch_valid <= 1'b1;
        end
    end

    // held while decode stalls
    always_ff @(posedge clk) begin
        if (!decode_stall) begin
            fetch_pc <= pc;
            fetch_instruction <= imem_data;
        end
    end

endmodule

`default_nettype wire

/* common/core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] reg_addr_t;

    localparam word_t reset_pc = 32'h0000_0000;
    localparam word_t pc_step = 32'd4;

    // major opcodes
    localparam logic [6:0] opcode_op = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_lui = 7'b0110111;
    localparam logic [6:0] opcode_branch = 7'b1100011;

    // arithmetic funct3, shared by op and op_imm
    localparam logic [2:0] funct3_add_sub = 3'b000;
    localparam logic [2:0] funct3_sll = 3'b001;
    localparam logic [2:0] funct3_slt = 3'b010;
    localparam logic [2:0] funct3_xor = 3'b100;
    localparam logic [2:0] funct3_srl = 3'b101;
    localparam logic [2:0] funct3_or = 3'b110;
    localparam logic [2:0] funct3_and = 3'b111;

    // branch funct3
    localparam logic [2:0] funct3_beq = 3'b000;
    localparam logic [2:0] funct3_bne = 3'b001;

    localparam logic [6:0] funct7_alt = 7'b0100000; // selects sub

    localparam word_t nop_instruction = 32'h0000_0013; // addi x0, x0, 0

    // pass_b forwards the second operand, used by lui and branches
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_xor,
        alu_or,
        alu_and,
        alu_sll,
        alu_srl,
        alu_pass_b
    } alu_op_t;

endpackage

`default_nettype wire
